/* project.f */
+incdir+source
source/udp_mux_pkg.sv
source/udp_frame_select.sv
source/udp_payload_skid.sv
source/udp_mux.sv
test/tb_udp_mux.sv

/* source/udp_frame_select.sv */
`include "udp_mux_config.svh"

module udp_frame_select (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  enable,
    input  logic [`UDP_MUX_SEL_WIDTH-1:0]         select,

    input  logic [`UDP_MUX_PORT_COUNT-1:0]        s_hdr_valid,
    output logic [`UDP_MUX_PORT_COUNT-1:0]        s_hdr_ready,
    input  udp_mux_pkg::udp_hdr_t                 s_hdr [`UDP_MUX_PORT_COUNT],
    input  logic [`UDP_MUX_PORT_COUNT-1:0]        s_pay_valid,
    output logic [`UDP_MUX_PORT_COUNT-1:0]        s_pay_ready,
    input  udp_mux_pkg::udp_beat_t                s_pay [`UDP_MUX_PORT_COUNT],

    output logic                                  m_hdr_valid,
    input  logic                                  m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t                 m_hdr,

    output logic                                  mid_valid,
    input  logic                                  mid_ready,
    output udp_mux_pkg::udp_beat_t                mid_pay
);

    import udp_mux_pkg::*;

    frame_state_t                  state;
    logic [`UDP_MUX_SEL_WIDTH-1:0] port_reg;
    logic                          hdr_valid_reg;
    udp_hdr_t                      hdr_reg;

    logic                          hdr_room;
    logic                          hdr_accept;
    logic                          cur_valid;
    udp_beat_t                     cur_beat;
    logic                          pay_xfer;

    // output header slot is free or being emptied this cycle
    assign hdr_room = !hdr_valid_reg || m_hdr_ready;

    // only the selected port may see header ready, and only between frames
    always_comb begin
        s_hdr_ready = '0;
        if (state == FRAME_IDLE && enable && hdr_room) begin
            s_hdr_ready[select] = 1'b1;
        end
    end

    assign hdr_accept = s_hdr_ready[select] && s_hdr_valid[select];

    // payload comes from the port latched at header time
    assign cur_valid = s_pay_valid[port_reg];
    assign cur_beat  = s_pay[port_reg];

    always_comb begin
        s_pay_ready = '0;
        if (state == FRAME_ACTIVE) begin
            s_pay_ready[port_reg] = mid_ready;
        end
    end

    assign pay_xfer = (state == FRAME_ACTIVE) && cur_valid && mid_ready;

    // mid_valid marks a beat that was actually taken from the source
    assign mid_valid = pay_xfer;
    assign mid_pay   = cur_beat;

    assign m_hdr_valid = hdr_valid_reg;
    assign m_hdr       = hdr_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FRAME_IDLE;
            port_reg      <= '0;
            hdr_valid_reg <= 1'b0;
        end else begin
            if (hdr_valid_reg && m_hdr_ready) begin
                hdr_valid_reg <= 1'b0;
            end
            case (state)
                FRAME_IDLE: begin
                    if (hdr_accept) begin
                        state         <= FRAME_ACTIVE;
                        port_reg      <= select;
                        hdr_valid_reg <= 1'b1;
                    end
                end
                FRAME_ACTIVE: begin
                    // frame closes on the beat carrying last
                    if (pay_xfer && cur_beat.last) begin
                        state <= FRAME_IDLE;
                    end
                end
                default: state <= FRAME_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr_reg <= s_hdr[select];
        end
    end

    // one header per frame, no port sees header ready once a frame has opened
    a_one_hdr_per_frame: assert property (@(posedge clk) disable iff (rst)
        hdr_accept |=> (s_hdr_ready == '0));

    // payload ready stays low between frames until a header is taken
    a_no_pay_when_idle: assert property (@(posedge clk) disable iff (rst)
        (state == FRAME_IDLE && !hdr_accept) |=> (s_pay_ready == '0));

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> (m_hdr_valid && $stable(m_hdr)));

endmodule

/* source/udp_mux.sv */
`include "udp_mux_config.svh"

module udp_mux (
    input  logic                                  clk,
    input  logic                                  rst,

    // sources
    input  logic [`UDP_MUX_PORT_COUNT-1:0]        s_hdr_valid,
    output logic [`UDP_MUX_PORT_COUNT-1:0]        s_hdr_ready,
    input  udp_mux_pkg::udp_hdr_t                 s_hdr [`UDP_MUX_PORT_COUNT],
    input  logic [`UDP_MUX_PORT_COUNT-1:0]        s_pay_valid,
    output logic [`UDP_MUX_PORT_COUNT-1:0]        s_pay_ready,
    input  udp_mux_pkg::udp_beat_t                s_pay [`UDP_MUX_PORT_COUNT],

    // sink
    output logic                                  m_hdr_valid,
    input  logic                                  m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t                 m_hdr,
    output logic                                  m_pay_valid,
    input  logic                                  m_pay_ready,
    output udp_mux_pkg::udp_beat_t                m_pay,

    // control
    input  logic                                  enable,
    input  logic [`UDP_MUX_SEL_WIDTH-1:0]         select
);

    import udp_mux_pkg::*;

    // payload between the selector and the output skid buffer
    logic      mid_valid;
    logic      mid_ready;
    udp_beat_t mid_pay;

    udp_frame_select u_frame_select (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .select      (select),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_hdr       (s_hdr),
        .s_pay_valid (s_pay_valid),
        .s_pay_ready (s_pay_ready),
        .s_pay       (s_pay),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr),
        .mid_valid   (mid_valid),
        .mid_ready   (mid_ready),
        .mid_pay     (mid_pay)
    );

    udp_payload_skid u_payload_skid (
        .clk         (clk),
        .rst         (rst),
        .mid_valid   (mid_valid),
        .mid_ready   (mid_ready),
        .mid_pay     (mid_pay),
        .m_pay_valid (m_pay_valid),
        .m_pay_ready (m_pay_ready),
        .m_pay       (m_pay)
    );

endmodule

/* source/udp_mux_config.svh */
`ifndef UDP_MUX_CONFIG_SVH
`define UDP_MUX_CONFIG_SVH

// number of udp source ports
`define UDP_MUX_PORT_COUNT 4

// log2 of the port count
`define UDP_MUX_SEL_WIDTH 2

// payload beat is one byte
`define UDP_MUX_DATA_WIDTH 8

`endif

/* source/udp_mux_pkg.sv */
`include "udp_mux_config.svh"

package udp_mux_pkg;

    // header fields that travel through the mux, 128 bits
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } udp_hdr_t;

    // one payload beat
    typedef struct packed {
        logic [`UDP_MUX_DATA_WIDTH-1:0] data;
        logic                           last;
        logic                           user;
    } udp_beat_t;

    // a frame is open from header acceptance to its last payload beat
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_t;

endpackage

/* source/udp_payload_skid.sv */
`include "udp_mux_config.svh"

module udp_payload_skid (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   mid_valid,
    output logic                   mid_ready,
    input  udp_mux_pkg::udp_beat_t mid_pay,

    output logic                   m_pay_valid,
    input  logic                   m_pay_ready,
    output udp_mux_pkg::udp_beat_t m_pay
);

    import udp_mux_pkg::*;

    logic      out_valid;
    udp_beat_t out_reg;
    logic      temp_valid;
    udp_beat_t temp_reg;
    logic      ready_reg;
    logic      ready_early;

    logic      out_valid_next;
    logic      temp_valid_next;
    logic      load_in_to_out;
    logic      load_in_to_temp;
    logic      load_temp_to_out;

    assign mid_ready   = ready_reg;
    assign m_pay_valid = out_valid;
    assign m_pay       = out_reg;

    // ready next cycle if the sink drains now, or a new beat cannot spill into temp
    assign ready_early = m_pay_ready || (!temp_valid && (!out_valid || !mid_valid));

    always_comb begin
        out_valid_next   = out_valid;
        temp_valid_next  = temp_valid;
        load_in_to_out   = 1'b0;
        load_in_to_temp  = 1'b0;
        load_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_pay_ready || !out_valid) begin
                // output slot free, go straight there
                out_valid_next = mid_valid;
                load_in_to_out = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next = mid_valid;
                load_in_to_temp = 1'b1;
            end
        end else if (m_pay_ready) begin
            out_valid_next   = temp_valid;
            temp_valid_next  = 1'b0;
            load_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_reg  <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_in_to_out) begin
            out_reg <= mid_pay;
        end else if (load_temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (load_in_to_temp) begin
            temp_reg <= mid_pay;
        end
    end

    // upstream only forwards beats it took under mid_ready, so there is always room
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        mid_valid |-> !(out_valid && temp_valid));

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (m_pay_valid && !m_pay_ready) |=> (m_pay_valid && $stable(m_pay)));

endmodule

/* test/tb_udp_mux.sv */
`include "udp_mux_config.svh"

module tb_udp_mux;

    timeunit 1ns;
    timeprecision 1ps;

    import udp_mux_pkg::*;

    localparam int PORTS     = `UDP_MUX_PORT_COUNT;
    localparam int MAX_REC   = 32;
    localparam int MAX_BYTES = 512;

    logic                          clk;
    logic                          rst;
    logic                          enable;
    logic [`UDP_MUX_SEL_WIDTH-1:0] select;
    logic [PORTS-1:0]              s_hdr_valid;
    logic [PORTS-1:0]              s_hdr_ready;
    udp_hdr_t                      s_hdr [PORTS];
    logic [PORTS-1:0]              s_pay_valid;
    logic [PORTS-1:0]              s_pay_ready;
    udp_beat_t                     s_pay [PORTS];
    logic                          m_hdr_valid;
    logic                          m_hdr_ready;
    udp_hdr_t                      m_hdr;
    logic                          m_pay_valid;
    logic                          m_pay_ready;
    udp_beat_t                     m_pay;

    // records from the data file
    int         rec_port [MAX_REC];
    int         rec_sel [MAX_REC];
    int         rec_en [MAX_REC];
    udp_hdr_t   rec_hdr [MAX_REC];
    int         rec_start [MAX_REC];
    int         rec_len [MAX_REC];
    logic [7:0] byte_mem [MAX_BYTES];
    int         n_rec;
    int         total_bytes;

    // per port source queues, and the expected sink streams
    udp_hdr_t   hdr_q [PORTS][$];
    logic [9:0] pay_q [PORTS][$];
    int         model_q [PORTS][$];
    udp_hdr_t   exp_hdr_q [$];
    logic [9:0] exp_pay_q [$];

    integer     seed = 32'h9194_f160;
    int         cycle_count = 0;
    int         cycle_limit = 1000;
    logic       frame_open = 1'b0;
    int         open_port = 0;
    logic       hdr_stall = 1'b0;
    logic       pay_stall = 1'b0;
    udp_hdr_t   prev_hdr;
    udp_beat_t  prev_pay;

    udp_mux dut0 (
        .clk         (clk),
        .rst         (rst),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_hdr       (s_hdr),
        .s_pay_valid (s_pay_valid),
        .s_pay_ready (s_pay_ready),
        .s_pay       (s_pay),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr),
        .m_pay_valid (m_pay_valid),
        .m_pay_ready (m_pay_ready),
        .m_pay       (m_pay),
        .enable      (enable),
        .select      (select)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // beat layout is data, last, user; user carries the byte parity
    function automatic logic [9:0] make_beat(input logic [7:0] b, input logic is_last);
        return {b, is_last, ^b};
    endfunction

    task automatic read_records();
        int    fd;
        int    code;
        int    port, sel, en, cnt;
        int    b;
        string line;
        logic [31:0] src, dst;
        logic [15:0] sp, dp, ln, cs;
        fd = $fopen("test/udp_mux_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the test data file");
        end
        n_rec = 0;
        total_bytes = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                               port, sel, en, src, dst, sp, dp, ln, cs, cnt);
                if (code == 10) begin
                    rec_port[n_rec]  = port;
                    rec_sel[n_rec]   = sel;
                    rec_en[n_rec]    = en;
                    rec_hdr[n_rec]   = {src, dst, sp, dp, ln, cs};
                    rec_start[n_rec] = total_bytes;
                    rec_len[n_rec]   = cnt;
                    for (int i = 0; i < cnt; i++) begin
                        code = $fscanf(fd, "%h", b);
                        byte_mem[total_bytes] = b[7:0];
                        total_bytes++;
                    end
                    n_rec++;
                end
            end
        end
        $fclose(fd);
    endtask

    // load every source and work out the order frames must leave in
    task automatic build_streams();
        int idx;
        for (int r = 0; r < n_rec; r++) begin
            model_q[rec_port[r]].push_back(r);
            hdr_q[rec_port[r]].push_back(rec_hdr[r]);
            for (int i = 0; i < rec_len[r]; i++) begin
                pay_q[rec_port[r]].push_back(
                    make_beat(byte_mem[rec_start[r] + i], i == rec_len[r] - 1));
            end
            if (rec_en[r] != 0) begin
                if (model_q[rec_sel[r]].size() == 0) begin
                    fail_run("test data selects a port with no frame queued");
                end
                idx = model_q[rec_sel[r]].pop_front();
                exp_hdr_q.push_back(rec_hdr[idx]);
                for (int i = 0; i < rec_len[idx]; i++) begin
                    exp_pay_q.push_back(
                        make_beat(byte_mem[rec_start[idx] + i], i == rec_len[idx] - 1));
                end
            end
        end
    endtask

    // sources present the head of their queues
    always @(posedge clk) begin
        for (int p = 0; p < PORTS; p++) begin
            if (s_hdr_valid[p] && s_hdr_ready[p]) begin
                void'(hdr_q[p].pop_front());
            end
            if (s_pay_valid[p] && s_pay_ready[p]) begin
                void'(pay_q[p].pop_front());
            end
            s_hdr_valid[p] <= (hdr_q[p].size() > 0);
            if (hdr_q[p].size() > 0) begin
                s_hdr[p] <= hdr_q[p][0];
            end
            s_pay_valid[p] <= (pay_q[p].size() > 0);
            if (pay_q[p].size() > 0) begin
                s_pay[p] <= pay_q[p][0];
            end
        end
    end

    // sink back-pressure
    always @(posedge clk) begin
        m_hdr_ready <= $random(seed);
        m_pay_ready <= $random(seed);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run("timeout, the expected frames did not all arrive");
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (!enable) begin
                check_value("s_hdr_ready", s_hdr_ready, '0);
            end
            if (frame_open) begin
                check_value("s_hdr_ready", s_hdr_ready, '0);
                check_value("s_pay_ready", s_pay_ready & ~(4'b1 << open_port), '0);
            end else begin
                check_value("s_pay_ready", s_pay_ready, '0);
            end
            for (int p = 0; p < PORTS; p++) begin
                if (s_hdr_valid[p] && s_hdr_ready[p]) begin
                    check_value("accepted port", p, select);
                    frame_open = 1'b1;
                    open_port  = p;
                end
            end
            if (frame_open && s_pay_valid[open_port] && s_pay_ready[open_port]
                && s_pay[open_port].last) begin
                frame_open = 1'b0;
            end

            if (hdr_stall) begin
                check_value("m_hdr_valid", m_hdr_valid, 1'b1);
                check_value("m_hdr", m_hdr, prev_hdr);
            end
            if (pay_stall) begin
                check_value("m_pay_valid", m_pay_valid, 1'b1);
                check_value("m_pay", m_pay, prev_pay);
            end
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    fail_run("an output header appeared with no frame expected");
                end
                check_value("m_hdr", m_hdr, exp_hdr_q.pop_front());
            end
            if (m_pay_valid && m_pay_ready) begin
                if (exp_pay_q.size() == 0) begin
                    fail_run("an output payload beat appeared with none expected");
                end
                check_value("m_pay", m_pay, exp_pay_q.pop_front());
            end
            hdr_stall = m_hdr_valid && !m_hdr_ready;
            pay_stall = m_pay_valid && !m_pay_ready;
            prev_hdr  = m_hdr;
            prev_pay  = m_pay;
        end
    end

    initial begin
        int sel;
        rst         = 1'b1;
        enable      = 1'b0;
        select      = '0;
        s_hdr_valid = '0;
        s_pay_valid = '0;
        m_hdr_ready = 1'b0;
        m_pay_ready = 1'b0;
        for (int p = 0; p < PORTS; p++) begin
            s_hdr[p] = '0;
            s_pay[p] = '0;
        end
        read_records();
        build_streams();
        cycle_limit = 200 + 20 * total_bytes;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // idle outputs until enable first goes high
        repeat (3) begin
            @(posedge clk);
            check_value("m_hdr_valid", m_hdr_valid, 1'b0);
            check_value("m_pay_valid", m_pay_valid, 1'b0);
            check_value("s_hdr_ready", s_hdr_ready, '0);
            check_value("s_pay_ready", s_pay_ready, '0);
        end

        for (int r = 0; r < n_rec; r++) begin
            sel = rec_sel[r];
            select <= sel;
            enable <= (rec_en[r] != 0);
            if (rec_en[r] != 0) begin
                do @(posedge clk);
                while (!(s_hdr_valid[sel] && s_hdr_ready[sel]));
                // move select away while the frame is still open
                select <= sel + 1;
                do @(posedge clk);
                while (!(s_pay_valid[sel] && s_pay_ready[sel] && s_pay[sel].last));
            end else begin
                repeat (6) @(posedge clk);
            end
        end
        // frames never selected stay queued at their sources
        enable <= 1'b0;

        do @(posedge clk);
        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0);
        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* test/udp_mux_testdata.txt */
# port select enable ip_src ip_dst udp_sport udp_dport udp_len udp_csum byte_count
# the payload bytes in hex follow on the next line
1 0 0 0a000001 0a000101 1f90 0035 000c 1111 4
de ad be ef
0 0 1 c0a80001 c0a80002 04d2 162e 000b 0000 3
01 02 03
2 1 1 ac100005 ac100006 3039 0050 000e abcd 6
10 20 30 40 50 60
3 2 1 0a0a0a0a 0b0b0b0b 8000 8001 0009 5a5a 1
ff
3 3 1 7f000001 7f000002 2710 2711 000d 1234 5
aa 55 aa 55 0f
1 3 1 c0a80164 c0a801c8 e000 0043 0010 fedc 8
00 11 22 33 44 55 66 77
0 1 1 08080808 08080404 0035 c350 000a 0f0f 2
80 7f
2 0 0 0a141e28 323c4650 1388 1389 000c 2468 4
c3 3c a5 5a
0 0 1 01020304 05060708 aaaa bbbb 000f 1357 7
01 23 45 67 89 ab cd
2 2 1 ac1f0001 ac1f00fe 0400 0401 000b 9999 3
fe dc ba
1 2 1 64646464 c8c8c8c8 1f40 1f41 000d 7777 5
13 57 9b df 02
3 0 1 0a00000a 0a0000fa 5000 5001 0009 0001 1
42
2 1 1 c0000201 c0000202 6000 6001 000e 8421 6
99 88 77 66 55 44
0 3 1 e0000001 e00000fb 14e9 14e9 000c cafe 4
de ca fb ad
